// ==== include/csc_settings.svh ====
`ifndef CSC_SETTINGS_SVH
`define CSC_SETTINGS_SVH

// Line geometry, at least three pairs per line
`define CSC_LINE_PAIRS 4

// Even and odd pixel lanes
`define CSC_LANES 2

// Pair slots in the packer FIFO
`define CSC_PACK_DEPTH 4

// Word slots granted downstream at reset
`define CSC_OUT_CREDITS 4

// Six-tap chroma filter, symmetric
`define CSC_TAP_OUTER 21
`define CSC_TAP_MID (-52)
`define CSC_TAP_INNER 159

// Colour matrix in 16-bit fixed point
`define CSC_COEF_Y 76284
`define CSC_COEF_RV 104595
`define CSC_COEF_GU (-25624)
`define CSC_COEF_GV (-53281)
`define CSC_COEF_BU 132251

// Sample offsets removed before the matrix
`define CSC_Y_OFFSET 16
`define CSC_C_OFFSET 128

`endif

// ==== source/csc_pkg.sv ====
package csc_pkg;

	// Unsigned sample or colour byte
	typedef logic [7:0] pixel_t;

	// Interpolated chroma may overshoot 0..255
	typedef logic signed [15:0] chroma_t;

	// Sum of products before clipping
	typedef logic signed [31:0] product_t;

	typedef logic [15:0] word_t;

	typedef enum logic [1:0] {
		LINE_FILL,
		LINE_RUN,
		LINE_FLUSH
	} upsample_state_e;

	// Word being emitted for the pair at the FIFO head
	typedef enum logic [1:0] {
		WORD_RG,
		WORD_BR,
		WORD_GB
	} pack_phase_e;

endpackage

// ==== source/chroma_upsampler.sv ====
`timescale 1ns/1ns
`include "csc_settings.svh"

module chroma_upsampler (
	input logic Clock,
	input logic resetn,
	input logic in_valid,
	input csc_pkg::pixel_t in_y_even,
	input csc_pkg::pixel_t in_y_odd,
	input csc_pkg::pixel_t in_u,
	input csc_pkg::pixel_t in_v,
	output logic in_ready,
	input logic pair_credit,
	output logic pair_valid,
	output csc_pkg::pixel_t lane_y [2],
	output csc_pkg::chroma_t lane_u [2],
	output csc_pkg::chroma_t lane_v [2]
);

	localparam int CNT_W = $clog2(`CSC_LINE_PAIRS);
	localparam int CR_W = $clog2(`CSC_PACK_DEPTH + 1);
	localparam logic [CNT_W-1:0] LINE_LAST = CNT_W'(`CSC_LINE_PAIRS - 1);

	csc_pkg::upsample_state_e state;
	csc_pkg::upsample_state_e state_n;
	logic [CNT_W-1:0] in_cnt;
	logic [CNT_W-1:0] in_cnt_n;
	logic [1:0] flush_cnt;
	logic [1:0] flush_cnt_n;
	logic [CR_W-1:0] credit_cnt;
	logic [CR_W-1:0] credit_cnt_n;
	logic win_full;
	logic win_full_n;
	logic issue;
	logic can_shift;
	logic accept;
	logic flush_step;

	// Window slot 2 is the pair being converted, slots 3..5 look ahead
	csc_pkg::pixel_t u_win [6];
	csc_pkg::pixel_t v_win [6];
	csc_pkg::pixel_t ye_win [4];
	csc_pkg::pixel_t yo_win [4];
	csc_pkg::chroma_t u_filt;
	csc_pkg::chroma_t v_filt;

	function automatic csc_pkg::chroma_t fir6(input csc_pkg::pixel_t c0, c1, c2, c3, c4, c5);
		csc_pkg::product_t acc;
		acc = `CSC_TAP_OUTER * ($signed({24'd0, c0}) + $signed({24'd0, c5}))
			+ `CSC_TAP_MID * ($signed({24'd0, c1}) + $signed({24'd0, c4}))
			+ `CSC_TAP_INNER * ($signed({24'd0, c2}) + $signed({24'd0, c3}))
			+ 32'sd128;
		return csc_pkg::chroma_t'(acc >>> 8);
	endfunction

	assign u_filt = fir6(u_win[0], u_win[1], u_win[2], u_win[3], u_win[4], u_win[5]);
	assign v_filt = fir6(v_win[0], v_win[1], v_win[2], v_win[3], v_win[4], v_win[5]);

	always_comb begin
		issue = win_full && (credit_cnt != '0);
		can_shift = !win_full || issue;
		accept = in_valid && in_ready;
		flush_step = (state == csc_pkg::LINE_FLUSH) && can_shift;

		state_n = state;
		in_cnt_n = in_cnt;
		flush_cnt_n = flush_cnt;
		win_full_n = win_full && !issue;
		credit_cnt_n = credit_cnt - CR_W'(issue) + CR_W'(pair_credit);

		case (state)
			csc_pkg::LINE_FILL: begin
				// First three samples only prime the window
				if (accept) begin
					in_cnt_n = in_cnt + 1'b1;
					if (in_cnt == LINE_LAST) begin
						state_n = csc_pkg::LINE_FLUSH;
						in_cnt_n = '0;
					end else if (in_cnt == CNT_W'(2)) begin
						state_n = csc_pkg::LINE_RUN;
					end
				end
			end
			csc_pkg::LINE_RUN: begin
				if (accept) begin
					win_full_n = 1'b1;
					in_cnt_n = in_cnt + 1'b1;
					if (in_cnt == LINE_LAST) begin
						state_n = csc_pkg::LINE_FLUSH;
						in_cnt_n = '0;
					end
				end
			end
			csc_pkg::LINE_FLUSH: begin
				// Three repeats of the last sample close the line
				if (flush_step) begin
					win_full_n = 1'b1;
					flush_cnt_n = flush_cnt + 1'b1;
					if (flush_cnt == 2'd2) begin
						state_n = csc_pkg::LINE_FILL;
						flush_cnt_n = '0;
					end
				end
			end
			default: begin
				state_n = csc_pkg::LINE_FILL;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			state <= csc_pkg::LINE_FILL;
			in_cnt <= '0;
			flush_cnt <= '0;
			win_full <= 1'b0;
			credit_cnt <= CR_W'(`CSC_PACK_DEPTH);
			in_ready <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			state <= state_n;
			in_cnt <= in_cnt_n;
			flush_cnt <= flush_cnt_n;
			win_full <= win_full_n;
			credit_cnt <= credit_cnt_n;
			// Ready next cycle if the window will shift then
			in_ready <= (state_n != csc_pkg::LINE_FLUSH) && (!win_full_n || credit_cnt_n != '0);
			pair_valid <= issue;
		end
	end

	always_ff @(posedge Clock) begin
		if (accept && state == csc_pkg::LINE_FILL && in_cnt == '0) begin
			// Left edge replication
			for (int i = 0; i < 6; i++) begin
				u_win[i] <= in_u;
				v_win[i] <= in_v;
			end
			for (int i = 0; i < 4; i++) begin
				ye_win[i] <= in_y_even;
				yo_win[i] <= in_y_odd;
			end
		end else if (accept || flush_step) begin
			for (int i = 0; i < 5; i++) begin
				u_win[i] <= u_win[i+1];
				v_win[i] <= v_win[i+1];
			end
			for (int i = 0; i < 3; i++) begin
				ye_win[i] <= ye_win[i+1];
				yo_win[i] <= yo_win[i+1];
			end
			if (accept) begin
				u_win[5] <= in_u;
				v_win[5] <= in_v;
				ye_win[3] <= in_y_even;
				yo_win[3] <= in_y_odd;
			end
		end

		if (issue) begin
			lane_y[0] <= ye_win[0];
			lane_y[1] <= yo_win[0];
			lane_u[0] <= csc_pkg::chroma_t'({8'd0, u_win[2]});
			lane_v[0] <= csc_pkg::chroma_t'({8'd0, v_win[2]});
			lane_u[1] <= u_filt;
			lane_v[1] <= v_filt;
		end
	end

	// Packer returns no more credits than were spent
	credit_bound: assert property (@(posedge Clock) disable iff (!resetn)
		credit_cnt <= CR_W'(`CSC_PACK_DEPTH))
		else $error("upsampler credit count above FIFO depth");

endmodule

// ==== source/csc_lane.sv ====
`timescale 1ns/1ns
`include "csc_settings.svh"

module csc_lane (
	input logic Clock,
	input logic resetn,
	input logic pair_valid,
	input csc_pkg::pixel_t y,
	input csc_pkg::chroma_t u,
	input csc_pkg::chroma_t v,
	output logic rgb_valid,
	output csc_pkg::pixel_t r,
	output csc_pkg::pixel_t g,
	output csc_pkg::pixel_t b
);

	csc_pkg::product_t y_off;
	csc_pkg::product_t u_off;
	csc_pkg::product_t v_off;
	csc_pkg::product_t p_y;
	csc_pkg::product_t p_rv;
	csc_pkg::product_t p_gu;
	csc_pkg::product_t p_gv;
	csc_pkg::product_t p_bu;
	csc_pkg::product_t r_sum;
	csc_pkg::product_t g_sum;
	csc_pkg::product_t b_sum;
	logic s1_valid;
	logic s2_valid;

	// Negative gives 0, overflow past bit 23 gives 255
	function automatic csc_pkg::pixel_t clip(input csc_pkg::product_t x);
		if (x[31])
			return 8'd0;
		if (|x[30:24])
			return 8'd255;
		return x[23:16];
	endfunction

	assign y_off = $signed({24'd0, y}) - `CSC_Y_OFFSET;
	assign u_off = csc_pkg::product_t'(u) - `CSC_C_OFFSET;
	assign v_off = csc_pkg::product_t'(v) - `CSC_C_OFFSET;

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			rgb_valid <= 1'b0;
		end else begin
			s1_valid <= pair_valid;
			s2_valid <= s1_valid;
			rgb_valid <= s2_valid;
		end
	end

	always_ff @(posedge Clock) begin
		p_y <= y_off * `CSC_COEF_Y;
		p_rv <= v_off * `CSC_COEF_RV;
		p_gu <= u_off * `CSC_COEF_GU;
		p_gv <= v_off * `CSC_COEF_GV;
		p_bu <= u_off * `CSC_COEF_BU;

		r_sum <= p_y + p_rv;
		g_sum <= p_y + p_gu + p_gv;
		b_sum <= p_y + p_bu;

		r <= clip(r_sum);
		g <= clip(g_sum);
		b <= clip(b_sum);
	end

endmodule

// ==== source/pixel_packer.sv ====
`timescale 1ns/1ns
`include "csc_settings.svh"

module pixel_packer (
	input logic Clock,
	input logic resetn,
	input logic rgb_valid,
	input csc_pkg::pixel_t r [2],
	input csc_pkg::pixel_t g [2],
	input csc_pkg::pixel_t b [2],
	output logic pair_credit,
	output logic out_valid,
	output csc_pkg::word_t out_data,
	input logic out_credit
);

	localparam int DEPTH = `CSC_PACK_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CR_W = $clog2(`CSC_OUT_CREDITS + 1);

	// One slot holds {R0, G0, B0, R1, G1, B1}
	logic [47:0] fifo_mem [DEPTH];
	logic [47:0] head;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fifo_cnt;
	logic [CR_W-1:0] credit_cnt;
	csc_pkg::pack_phase_e phase;
	csc_pkg::word_t word;
	logic send;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head = fifo_mem[rd_ptr];
	// The word on the bus this cycle already holds one credit
	assign send = (fifo_cnt != '0) && (credit_cnt > CR_W'(out_valid));
	assign pop = send && (phase == csc_pkg::WORD_GB);

	always_comb begin
		case (phase)
			csc_pkg::WORD_RG: word = head[47:32];
			csc_pkg::WORD_BR: word = head[31:16];
			default: word = head[15:0];
		endcase
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			credit_cnt <= CR_W'(`CSC_OUT_CREDITS);
			phase <= csc_pkg::WORD_RG;
			out_valid <= 1'b0;
			pair_credit <= 1'b0;
		end else begin
			if (rgb_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			fifo_cnt <= fifo_cnt + CNT_W'(rgb_valid) - CNT_W'(pop);
			credit_cnt <= credit_cnt - CR_W'(out_valid) + CR_W'(out_credit);
			if (send) begin
				case (phase)
					csc_pkg::WORD_RG: phase <= csc_pkg::WORD_BR;
					csc_pkg::WORD_BR: phase <= csc_pkg::WORD_GB;
					default: phase <= csc_pkg::WORD_RG;
				endcase
			end
			out_valid <= send;
			pair_credit <= pop;
		end
	end

	always_ff @(posedge Clock) begin
		if (rgb_valid)
			fifo_mem[wr_ptr] <= {r[0], g[0], b[0], r[1], g[1], b[1]};
		if (send)
			out_data <= word;
	end

	// Upsampler credits keep the lanes from overrunning the FIFO
	fifo_no_overflow: assert property (@(posedge Clock) disable iff (!resetn)
		rgb_valid |-> fifo_cnt != CNT_W'(DEPTH))
		else $error("pair written into full packer FIFO");

	out_credit_held: assert property (@(posedge Clock) disable iff (!resetn)
		out_valid |-> credit_cnt != '0)
		else $error("output word sent without credit");

endmodule

// ==== source/yuv_to_rgb_top.sv ====
`timescale 1ns/1ns
`include "csc_settings.svh"

module yuv_to_rgb_top (
	input logic Clock,
	input logic resetn,
	input logic in_valid,
	input csc_pkg::pixel_t in_y_even,
	input csc_pkg::pixel_t in_y_odd,
	input csc_pkg::pixel_t in_u,
	input csc_pkg::pixel_t in_v,
	output logic in_ready,
	output logic out_valid,
	output csc_pkg::word_t out_data,
	input logic out_credit
);

	logic pair_valid;
	logic pair_credit;
	logic [`CSC_LANES-1:0] lane_rgb_valid;
	csc_pkg::pixel_t lane_y [`CSC_LANES];
	csc_pkg::chroma_t lane_u [`CSC_LANES];
	csc_pkg::chroma_t lane_v [`CSC_LANES];
	csc_pkg::pixel_t lane_r [`CSC_LANES];
	csc_pkg::pixel_t lane_g [`CSC_LANES];
	csc_pkg::pixel_t lane_b [`CSC_LANES];

	chroma_upsampler u_upsampler (
		.Clock(Clock),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_y_even(in_y_even),
		.in_y_odd(in_y_odd),
		.in_u(in_u),
		.in_v(in_v),
		.in_ready(in_ready),
		.pair_credit(pair_credit),
		.pair_valid(pair_valid),
		.lane_y(lane_y),
		.lane_u(lane_u),
		.lane_v(lane_v)
	);

	// Lane 0 is the even pixel, lane 1 the odd pixel
	genvar i;
	generate
		for (i = 0; i < `CSC_LANES; i++) begin : g_lane
			csc_lane u_lane (
				.Clock(Clock),
				.resetn(resetn),
				.pair_valid(pair_valid),
				.y(lane_y[i]),
				.u(lane_u[i]),
				.v(lane_v[i]),
				.rgb_valid(lane_rgb_valid[i]),
				.r(lane_r[i]),
				.g(lane_g[i]),
				.b(lane_b[i])
			);
		end
	endgenerate

	pixel_packer u_packer (
		.Clock(Clock),
		.resetn(resetn),
		.rgb_valid(lane_rgb_valid[0]),
		.r(lane_r),
		.g(lane_g),
		.b(lane_b),
		.pair_credit(pair_credit),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_credit(out_credit)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic Clock,
	output logic resetn
);

	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 16;

	initial begin
		Clock = 1'b0;
		forever #HALF_PERIOD Clock = ~Clock;
	end

	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clock);
		// Release away from the active edge
		@(negedge Clock);
		resetn = 1'b1;
	end

endmodule

// ==== dv/tb_yuv_to_rgb.sv ====
`timescale 1ns/1ns
`include "csc_settings.svh"

module tb_yuv_to_rgb;

	localparam int SEED = 32'hee27b9b9;
	localparam int DRAIN_CYCLES = 20;
	localparam string VECTOR_FILE = "dv/yuv_vectors.txt";

	logic Clock;
	logic resetn;
	logic in_valid;
	csc_pkg::pixel_t in_y_even;
	csc_pkg::pixel_t in_y_odd;
	csc_pkg::pixel_t in_u;
	csc_pkg::pixel_t in_v;
	logic in_ready;
	logic out_valid;
	csc_pkg::word_t out_data;
	logic out_credit;

	// Input beats, then expected words with the test each belongs to
	csc_pkg::pixel_t beat_ye [$];
	csc_pkg::pixel_t beat_yo [$];
	csc_pkg::pixel_t beat_u [$];
	csc_pkg::pixel_t beat_v [$];
	csc_pkg::word_t exp_word [$];
	string exp_name [$];

	int n_beats;
	int n_words;
	int beat_idx;
	int word_idx;
	int credit_avail;
	int credit_owed;
	logic fire;

	tb_clock_gen u_clock (
		.Clock(Clock),
		.resetn(resetn)
	);

	yuv_to_rgb_top i_dut (
		.Clock(Clock),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_y_even(in_y_even),
		.in_y_odd(in_y_odd),
		.in_u(in_u),
		.in_v(in_v),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_credit(out_credit)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_word(input string name, input int index,
			input csc_pkg::word_t expected, input csc_pkg::word_t actual);
		if (actual !== expected)
			fail_run($sformatf("Error: %s word %0d expected %h actual %h",
				name, index, expected, actual));
	endtask

	task automatic check_credit(input int avail);
		if (avail <= 0)
			fail_run("DUT raised out_valid with no output credit left");
	endtask

	task automatic read_vectors();
		int fd;
		int got;
		string line;
		string name;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		name = "unnamed";
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0)
			fail_run("cannot open the vector file dv/yuv_vectors.txt");
		while ($fgets(line, fd) != 0) begin
			if (line[0] == "T") begin
				got = $sscanf(line, "T %s", name);
			end else if (line[0] == "I") begin
				got = $sscanf(line, "I %h %h %h %h", f0, f1, f2, f3);
				if (got != 4)
					fail_run("malformed input line in the vector file");
				beat_ye.push_back(csc_pkg::pixel_t'(f0));
				beat_yo.push_back(csc_pkg::pixel_t'(f1));
				beat_u.push_back(csc_pkg::pixel_t'(f2));
				beat_v.push_back(csc_pkg::pixel_t'(f3));
			end else if (line[0] == "O") begin
				got = $sscanf(line, "O %h %h %h", f0, f1, f2);
				if (got != 3)
					fail_run("malformed output line in the vector file");
				exp_word.push_back(csc_pkg::word_t'(f0));
				exp_word.push_back(csc_pkg::word_t'(f1));
				exp_word.push_back(csc_pkg::word_t'(f2));
				repeat (3) exp_name.push_back(name);
			end
		end
		$fclose(fd);
	endtask

	// Second pass of the same stream with input gaps and scarce credits
	task automatic add_stalled_pass(input int pass_beats, input int pass_words);
		for (int i = 0; i < pass_beats; i++) begin
			beat_ye.push_back(beat_ye[i]);
			beat_yo.push_back(beat_yo[i]);
			beat_u.push_back(beat_u[i]);
			beat_v.push_back(beat_v[i]);
		end
		for (int i = 0; i < pass_words; i++) begin
			exp_word.push_back(exp_word[i]);
			exp_name.push_back({"stalled_", exp_name[i]});
		end
	endtask

	task automatic step_input(input int pass_beats);
		logic gap;
		if (fire)
			beat_idx++;
		gap = (beat_idx >= pass_beats) && ($urandom % 3 == 0);
		if (beat_idx >= n_beats || gap) begin
			in_valid = 1'b0;
		end else begin
			in_valid = 1'b1;
			in_y_even = beat_ye[beat_idx];
			in_y_odd = beat_yo[beat_idx];
			in_u = beat_u[beat_idx];
			in_v = beat_v[beat_idx];
		end
		// in_ready holds until the next rising edge
		fire = in_valid && in_ready;
	endtask

	task automatic collect_output();
		if (out_valid) begin
			check_credit(credit_avail);
			credit_avail--;
			if (word_idx >= n_words)
				fail_run("DUT sent a word beyond the expected sequence");
			check_word(exp_name[word_idx], word_idx, exp_word[word_idx], out_data);
			word_idx++;
			credit_owed++;
		end
	endtask

	task automatic return_credit(input int pass_words);
		logic give;
		if (word_idx < pass_words)
			give = credit_owed > 0;
		else
			give = (credit_owed > 0) && ($urandom % 4 == 0);
		out_credit = give;
		if (give) begin
			credit_owed--;
			credit_avail++;
		end
	endtask

	initial begin
		int pass_beats;
		int pass_words;
		int limit;
		int cycles;
		int drain;
		in_valid = 1'b0;
		in_y_even = '0;
		in_y_odd = '0;
		in_u = '0;
		in_v = '0;
		out_credit = 1'b0;
		fire = 1'b0;
		void'($urandom(SEED));

		read_vectors();
		pass_beats = beat_ye.size();
		pass_words = exp_word.size();
		if (pass_beats == 0 || pass_beats % `CSC_LINE_PAIRS != 0)
			fail_run("vector file does not hold a whole number of lines");
		if (pass_words != 3 * pass_beats)
			fail_run("vector file needs three expected words per input beat");
		add_stalled_pass(pass_beats, pass_words);

		n_beats = beat_ye.size();
		n_words = exp_word.size();
		limit = 4 * n_words + 200;
		beat_idx = 0;
		word_idx = 0;
		credit_avail = `CSC_OUT_CREDITS;
		credit_owed = 0;
		cycles = 0;
		drain = 0;

		@(posedge resetn);
		if (in_ready !== 1'b0 || out_valid !== 1'b0)
			fail_run("in_ready or out_valid was high at the end of reset");
		while (word_idx < n_words || drain < DRAIN_CYCLES) begin
			@(negedge Clock);
			cycles++;
			if (cycles > limit)
				fail_run("timeout: output words stopped arriving before the end");
			step_input(pass_beats);
			collect_output();
			return_credit(pass_words);
			if (word_idx == n_words)
				drain++;
		end

		if (word_idx == n_words && beat_idx == n_beats) begin
			$display("TB PASSED");
			$finish;
		end else begin
			fail_run("run ended with input beats still waiting");
		end
	end

endmodule

// ==== dv/yuv_vectors.txt ====
# I y_even y_odd u v : one input pair beat, hex
# O w0 w1 w2 : expected {R0,G0} {B0,R1} {G1,B1} for that pair, hex; T names the test
T flat_grey
I 80 80 80 80
O 8282 8282 8282
I 80 80 80 80
O 8282 8282 8282
I 80 80 80 80
O 8282 8282 8282
I 80 80 80 80
O 8282 8282 8282
T clipping
I ff 00 00 ff
O ffe0 13b8 0000
I ff 00 00 ff
O ffe0 13b8 0000
I 00 ff 00 ff
O b800 00ff e013
I 00 ff 00 ff
O b800 00ff e013
T ramp_interp
I 80 80 50 b0
O ce6e 21b7 743f
I 80 80 70 90
O 9b7b 6282 8282
I 80 80 90 70
O 6889 a24d 90c4
I 80 80 b0 50
O 3596 e334 97e5
T line_restart
I 80 80 80 80
O 8282 8282 8282
I 80 80 80 80
O 8282 8282 8282
I 80 80 80 80
O 8282 8282 8282
I 80 80 80 80
O 8282 8282 8282

// ==== build.f ====
+incdir+include
source/csc_pkg.sv
source/chroma_upsampler.sv
source/csc_lane.sv
source/pixel_packer.sv
source/yuv_to_rgb_top.sv
dv/tb_clock_gen.sv
dv/tb_yuv_to_rgb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the YUV to RGB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_yuv_to_rgb -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0
